// File: bench/rx_patterns.txt
# pkt <id> <op> <vc> <crc_flip> <header> <data words...>, hex; header bits 3:0 = data word count
# crc_flip is xored into the reference CRC word (nonzero = bad packet); hold/release gate host pops
pkt 01 0 0 00000000 C0DE0002 12345678 9ABCDEF0
pkt 02 1 1 00000000 A1000000
pkt 03 2 0 00000001 B2000003 00000001 00000002 00000003
pkt 04 3 1 00000000 B4000001 FFFFFFFF
pkt 1F 1 0 80000000 D5000004 01020304 05060708 090A0B0C 0D0E0F10
pkt 10 0 1 00000000 E600000F
    00000000 11111111 22222222 33333333 44444444
    55555555 66666666 77777777 88888888 99999999
    AAAAAAAA BBBBBBBB CCCCCCCC DDDDDDDD EEEEEEEE
pkt 05 2 0 00000000 F7000002 DEADBEEF 0BADF00D
pkt 11 3 1 00000000 12340003 CAFEBABE 8BADF00D FEEDFACE
hold
pkt 06 0 0 00000000 10000001 A5A5A5A5
pkt 07 1 1 00000000 20000002 5A5A5A5A C3C3C3C3
pkt 08 2 0 00000000 30000000
pkt 09 3 1 00000000 40000003 00FF00FF FF00FF00 0F0F0F0F
pkt 0A 0 0 00000000 50000001 F0F0F0F0
release
pkt 0B 1 1 00000000 60000002 13579BDF 2468ACE0
pkt 0C 2 0 00010000 70000001 CAFEF00D
pkt 0D 3 1 00000000 80000003 11223344 55667788 99AABBCC
pkt 0E 0 0 00000000 90000000
pkt 15 1 0 FFFFFFFF 91000002 00000000 00000000
pkt 16 2 1 00000000 92000004 76543210 FEDCBA98 01234567 89ABCDEF
pkt 17 3 0 00000000 93000001 00000001

// File: files.f
rtl/flit_pkg.sv
rtl/rx_pkg.sv
rtl/crc_unit.sv
rtl/rx_fsm.sv
rtl/rx_buffer.sv
rtl/req_fifo.sv
rtl/rx_endpoint.sv
bench/rx_endpoint_tb.sv

// File: bench/rx_endpoint_tb.sv
module rx_endpoint_tb;

    localparam int BUF_AW       = rx_pkg::BUF_AW;
    localparam int FIFO_DEPTH   = 4;
    localparam int VC_W         = $clog2(flit_pkg::NUM_VC);
    localparam int MAX_ITEMS    = 64;
    localparam int STALL_CYCLES = 20;
    localparam int KIND_PKT     = 0;
    localparam int KIND_HOLD    = 1;
    localparam int KIND_RELEASE = 2;

    logic                        clk;
    logic                        n_rst;
    logic                        flit_valid;
    flit_pkg::word_t             flit_payload;
    flit_pkg::flit_id_t          flit_id;
    flit_pkg::req_e              flit_req;
    logic [VC_W-1:0]             flit_vc;
    logic                        flit_taken;
    logic [flit_pkg::NUM_VC-1:0] credit_granted;
    logic                        crc_error;
    logic                        req_valid;
    rx_pkg::meta_t               req_meta;
    logic [BUF_AW-1:0]           req_addr;
    logic                        req_pop;
    logic [BUF_AW-1:0]           rd_addr;
    flit_pkg::word_t             rd_data;

    int                 item_kind  [MAX_ITEMS];
    int                 item_len   [MAX_ITEMS]; // header plus data words.
    flit_pkg::word_t    item_words [MAX_ITEMS][16];
    flit_pkg::flit_id_t item_id    [MAX_ITEMS];
    flit_pkg::req_e     item_req   [MAX_ITEMS];
    logic [VC_W-1:0]    item_vc    [MAX_ITEMS];
    flit_pkg::word_t    item_flip  [MAX_ITEMS];
    int                 num_items;
    int                 total_flits;
    int                 taken_count;
    int                 exp_q[$];      // good packets whose FIFO entry is still due.
    logic [BUF_AW-1:0]  exp_addr_q[$];
    logic [BUF_AW-1:0]  shadow_ptr;
    logic [31:0]        lfsr;
    logic               loaded;
    logic               pops_on;
    logic               host_busy;
    logic               stall_pending;
    logic               crc_flit;
    logic               expect_bad;

    rx_endpoint #(
        .BUF_AW(BUF_AW),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) DUT (
        .clk(clk),
        .n_rst(n_rst),
        .flit_valid(flit_valid),
        .flit_payload(flit_payload),
        .flit_id(flit_id),
        .flit_req(flit_req),
        .flit_vc(flit_vc),
        .flit_taken(flit_taken),
        .credit_granted(credit_granted),
        .crc_error(crc_error),
        .req_valid(req_valid),
        .req_meta(req_meta),
        .req_addr(req_addr),
        .req_pop(req_pop),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    always #50 clk = ~clk;

    task automatic mismatch(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("Error at %0t: %s expected %h actual %h", $time, name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s (time %0t)", why, $time);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = galois_step(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    // one bit at a time, MSB first, which gives the same result as bytewise folding.
    function automatic flit_pkg::word_t crc_ref(input flit_pkg::word_t crc,
                                                input flit_pkg::word_t w);
        logic fb;
        for (int i = 31; i >= 0; i--) begin
            fb  = crc[31] ^ w[i];
            crc = crc << 1;
            if (fb) begin
                crc = crc ^ flit_pkg::CRC_POLY;
            end
        end
        return crc;
    endfunction

    task automatic load_patterns();
        int               fd;
        int               n;
        logic [8*16-1:0]  tok;
        logic [8*200-1:0] rest;
        logic [31:0]      v_id;
        logic [31:0]      v_req;
        logic [31:0]      v_vc;
        logic [31:0]      v_flip;
        logic [31:0]      v_word;
        fd = $fopen("bench/rx_patterns.txt", "r");
        assert (fd != 0) else abort_run("cannot open bench/rx_patterns.txt");
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(rest, fd);
            end else if (tok == "hold" || tok == "release") begin
                item_kind[num_items] = (tok == "hold") ? KIND_HOLD : KIND_RELEASE;
                num_items++;
            end else if (tok == "pkt") begin
                n = $fscanf(fd, "%h %h %h %h %h", v_id, v_req, v_vc, v_flip, v_word);
                assert (n == 5) else abort_run("malformed pkt line in the pattern file");
                item_kind[num_items]     = KIND_PKT;
                item_id[num_items]       = v_id[4:0];
                item_req[num_items]      = flit_pkg::req_e'(v_req[1:0]);
                item_vc[num_items]       = v_vc[VC_W-1:0];
                item_flip[num_items]     = v_flip;
                item_len[num_items]      = int'(v_word[3:0]) + 1; // length field is bits 3 to 0.
                item_words[num_items][0] = v_word;
                for (int w = 1; w < item_len[num_items]; w++) begin
                    n = $fscanf(fd, "%h", v_word);
                    assert (n == 1) else abort_run("missing data word in the pattern file");
                    item_words[num_items][w] = v_word;
                end
                total_flits += item_len[num_items] + 1;
                num_items++;
            end else begin
                abort_run("unknown keyword in the pattern file");
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_taken();
        @(negedge clk);
        while (!flit_taken) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
    endtask

    // the header stays offered while the FSM waits for room in the full FIFO.
    task automatic hold_check();
        int held;
        held = exp_q.size() - (expect_bad ? 0 : 1); // the offered packet has no entry yet.
        assert (held > FIFO_DEPTH) else abort_run("the burst did not fill the FIFO");
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            assert (!flit_taken) else mismatch("flit_taken", 0, flit_taken);
            assert (req_valid) else mismatch("req_valid", 1, req_valid);
        end
        @(posedge clk);
        #10;
        stall_pending = 1'b0;
        pops_on       = 1'b1;
    endtask

    task automatic send_packet(input int k);
        flit_pkg::word_t crc;
        flit_pkg::word_t crc_word;
        int              gap;
        crc = flit_pkg::CRC_SEED;
        for (int w = 0; w < item_len[k]; w++) begin
            crc = crc_ref(crc, item_words[k][w]);
        end
        crc_word   = crc ^ item_flip[k];
        expect_bad = (crc_word != crc);
        if (!expect_bad) begin
            exp_q.push_back(k);
            exp_addr_q.push_back(shadow_ptr);
            shadow_ptr = shadow_ptr + BUF_AW'(item_len[k]);
        end
        for (int w = 0; w <= item_len[k]; w++) begin
            flit_valid   = 1'b1;
            flit_payload = (w == item_len[k]) ? crc_word : item_words[k][w];
            flit_id      = item_id[k];
            flit_req     = item_req[k];
            flit_vc      = item_vc[k];
            crc_flit     = (w == item_len[k]);
            if (stall_pending) begin
                hold_check();
            end
            wait_taken();
            random_bits(2, gap);
            if (gap != 0) begin
                flit_valid = 1'b0;
                repeat (gap) begin
                    @(posedge clk);
                    #10;
                end
            end
        end
        flit_valid = 1'b0;
        crc_flit   = 1'b0;
    endtask

    always @(negedge clk) begin
        logic [flit_pkg::NUM_VC-1:0] exp_credit;
        if (n_rst) begin
            exp_credit = '0;
            if (flit_taken) begin
                exp_credit[flit_vc] = 1'b1;
                taken_count++;
            end
            assert (credit_granted == exp_credit)
                else mismatch("credit_granted", exp_credit, credit_granted);
            assert (crc_error == (flit_taken && crc_flit && expect_bad))
                else mismatch("crc_error", flit_taken && crc_flit && expect_bad, crc_error);
        end
    end

    initial begin : host
        int                k;
        int                pick;
        logic [BUF_AW-1:0] a;
        wait (n_rst === 1'b1);
        forever begin
            @(negedge clk);
            if (req_valid && pops_on) begin
                random_bits(1, pick);
                if (pick == 1) begin
                    host_busy = 1'b1;
                    assert (exp_q.size() != 0)
                        else abort_run("the FIFO shows an entry that no good packet produced");
                    k = exp_q.pop_front();
                    a = exp_addr_q.pop_front();
                    assert (req_meta == {item_id[k], item_req[k]})
                        else mismatch("req_meta", {item_id[k], item_req[k]}, req_meta);
                    assert (req_addr == a) else mismatch("req_addr", a, req_addr);
                    @(posedge clk);
                    #10 req_pop = 1'b1;
                    @(posedge clk);
                    #10 req_pop = 1'b0;
                    for (int i = 0; i < item_len[k]; i++) begin
                        rd_addr = a + BUF_AW'(i);
                        @(negedge clk);
                        @(negedge clk);
                        assert (rd_data == item_words[k][i])
                            else mismatch("rd_data", item_words[k][i], rd_data);
                        @(posedge clk);
                        #10;
                    end
                    host_busy = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        wait (loaded === 1'b1);
        repeat (40 * total_flits + 200) @(posedge clk);
        abort_run("timeout: packets were not all received and drained in time");
    end

    initial begin : stimulus
        clk           = 1'b0;
        n_rst         = 1'b0;
        flit_valid    = 1'b0;
        flit_payload  = '0;
        flit_id       = '0;
        flit_req      = flit_pkg::READ;
        flit_vc       = '0;
        req_pop       = 1'b0;
        rd_addr       = '0;
        lfsr          = 32'h6432_0f1f;
        shadow_ptr    = '0;
        loaded        = 1'b0;
        pops_on       = 1'b1;
        host_busy     = 1'b0;
        stall_pending = 1'b0;
        crc_flit      = 1'b0;
        expect_bad    = 1'b0;
        num_items     = 0;
        total_flits   = 0;
        taken_count   = 0;
        load_patterns();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (!flit_taken) else mismatch("flit_taken", 0, flit_taken);
        assert (credit_granted == '0) else mismatch("credit_granted", 0, credit_granted);
        assert (!crc_error) else mismatch("crc_error", 0, crc_error);
        assert (!req_valid) else mismatch("req_valid", 0, req_valid);
        @(posedge clk);
        #10 n_rst = 1'b1;
        for (int k = 0; k < num_items; k++) begin
            if (item_kind[k] == KIND_HOLD) begin
                while (exp_q.size() != 0) begin
                    @(posedge clk);
                    #10;
                end
                pops_on = 1'b0;
            end else if (item_kind[k] == KIND_RELEASE) begin
                stall_pending = 1'b1; // the next header checks the stall, then pops resume.
            end else begin
                send_packet(k);
            end
        end
        while (exp_q.size() != 0 || host_busy) begin
            @(negedge clk);
        end
        @(negedge clk);
        assert (!req_valid) else mismatch("req_valid", 0, req_valid);
        assert (taken_count == total_flits)
            else mismatch("flits taken", total_flits, taken_count);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: rtl/rx_endpoint.sv
module rx_endpoint #(
    parameter int BUF_AW     = rx_pkg::BUF_AW,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                flit_valid,
    input  flit_pkg::word_t                     flit_payload,
    input  flit_pkg::flit_id_t                  flit_id,
    input  flit_pkg::req_e                      flit_req,
    input  logic [$clog2(flit_pkg::NUM_VC)-1:0] flit_vc,
    output logic                                flit_taken,
    output logic [flit_pkg::NUM_VC-1:0]         credit_granted,
    output logic                                crc_error,
    output logic                                req_valid,
    output rx_pkg::meta_t                       req_meta,
    output logic [BUF_AW-1:0]                   req_addr,
    input  logic                                req_pop,
    input  logic [BUF_AW-1:0]                   rd_addr,
    output flit_pkg::word_t                     rd_data
);

    logic               crc_clear;
    logic               crc_update;
    flit_pkg::word_t    crc_value;
    logic               crc_done;
    logic               buf_wen;
    logic [BUF_AW-1:0]  buf_waddr;
    flit_pkg::word_t    buf_wdata;
    logic               req_push;
    logic               req_full;
    rx_pkg::req_entry_t req_entry;
    rx_pkg::req_entry_t req_head;

    assign req_meta = req_head.meta;
    assign req_addr = req_head.addr;

    rx_fsm #(
        .BUF_AW(BUF_AW)
    ) u_rx_fsm (
        .clk(clk),
        .n_rst(n_rst),
        .flit_valid(flit_valid),
        .flit_payload(flit_payload),
        .flit_id(flit_id),
        .flit_req(flit_req),
        .flit_vc(flit_vc),
        .crc_value(crc_value),
        .crc_done(crc_done),
        .req_full(req_full),
        .flit_taken(flit_taken),
        .credit_granted(credit_granted),
        .crc_error(crc_error),
        .crc_clear(crc_clear),
        .crc_update(crc_update),
        .buf_wen(buf_wen),
        .buf_waddr(buf_waddr),
        .buf_wdata(buf_wdata),
        .req_push(req_push),
        .req_entry(req_entry)
    );

    crc_unit u_crc_unit (
        .clk(clk),
        .n_rst(n_rst),
        .clear(crc_clear),
        .update(crc_update),
        .data_in(flit_payload), // the CRC runs over the flit currently offered.
        .crc_value(crc_value),
        .done(crc_done)
    );

    rx_buffer #(
        .BUF_AW(BUF_AW)
    ) u_rx_buffer (
        .clk(clk),
        .wen(buf_wen),
        .waddr(buf_waddr),
        .wdata(buf_wdata),
        .raddr(rd_addr),
        .rdata(rd_data)
    );

    req_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_req_fifo (
        .clk(clk),
        .n_rst(n_rst),
        .push(req_push),
        .entry_in(req_entry),
        .pop(req_pop),
        .full(req_full),
        .valid(req_valid),
        .head(req_head)
    );

endmodule

// File: rtl/req_fifo.sv
module req_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               push,
    input  rx_pkg::req_entry_t entry_in,
    input  logic               pop,
    output logic               full,
    output logic               valid,
    output rx_pkg::req_entry_t head
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    rx_pkg::req_entry_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign valid   = (count != '0);
    assign do_push = push && !full;
    assign do_pop  = pop && valid; // a pop on an empty FIFO does nothing.
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + CNT_W'(1);
            end else if (do_pop && !do_push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_in;
        end
    end

    // the receive FSM holds in its request state while the FIFO is full.
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!n_rst) push |-> !full
    );

endmodule

// File: rtl/rx_buffer.sv
module rx_buffer #(
    parameter int BUF_AW = rx_pkg::BUF_AW
) (
    input  logic              clk,
    input  logic              wen,
    input  logic [BUF_AW-1:0] waddr,
    input  flit_pkg::word_t   wdata,
    input  logic [BUF_AW-1:0] raddr,
    output flit_pkg::word_t   rdata
);

    localparam int DEPTH = 2 ** BUF_AW;

    flit_pkg::word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[raddr]; // host sees the word one cycle after the address.
    end

endmodule

// File: rtl/rx_fsm.sv
module rx_fsm #(
    parameter int BUF_AW = rx_pkg::BUF_AW
) (
    input  logic                                clk,
    input  logic                                n_rst,
    input  logic                                flit_valid,
    input  flit_pkg::word_t                     flit_payload,
    input  flit_pkg::flit_id_t                  flit_id,
    input  flit_pkg::req_e                      flit_req,
    input  logic [$clog2(flit_pkg::NUM_VC)-1:0] flit_vc,
    input  flit_pkg::word_t                     crc_value,
    input  logic                                crc_done,
    input  logic                                req_full,
    output logic                                flit_taken,
    output logic [flit_pkg::NUM_VC-1:0]         credit_granted,
    output logic                                crc_error,
    output logic                                crc_clear,
    output logic                                crc_update,
    output logic                                buf_wen,
    output logic [BUF_AW-1:0]                   buf_waddr,
    output flit_pkg::word_t                     buf_wdata,
    output logic                                req_push,
    output rx_pkg::req_entry_t                  req_entry
);

    localparam int CNT_W = $clog2(flit_pkg::MAX_DATA_WORDS + 2); // header plus data words.

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        CRC_WAIT,
        BODY,
        CRC_CHECK,
        REQ_EN
    } state_e;

    state_e             state;
    state_e             next_state;
    logic [BUF_AW-1:0]  next_waddr;
    logic [BUF_AW-1:0]  start_addr;
    logic [CNT_W-1:0]   word_total;
    logic [CNT_W-1:0]   words_done;
    logic [CNT_W-1:0]   next_words_done;
    rx_pkg::meta_t      meta_q;
    logic               last_word;

    // the request entry carries the address at the package width.
    if (BUF_AW != rx_pkg::BUF_AW) begin : g_aw_check
        $error("rx_fsm: BUF_AW must equal rx_pkg::BUF_AW");
    end

    assign last_word = (words_done == word_total); // only the CRC word is still to come.
    assign buf_wdata = flit_payload;
    assign req_entry = '{meta: meta_q, addr: start_addr};

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state      <= IDLE;
            buf_waddr  <= '0;
            words_done <= '0;
        end else begin
            state      <= next_state;
            buf_waddr  <= next_waddr;
            words_done <= next_words_done;
        end
    end

    always_ff @(posedge clk) begin
        if (state == HEADER) begin
            meta_q     <= '{id: flit_id, req: flit_req};
            start_addr <= buf_waddr;
            word_total <= CNT_W'(flit_pkg::data_word_count(flit_payload)) + CNT_W'(1);
        end
    end

    always_comb begin
        next_state      = state;
        next_waddr      = buf_waddr;
        next_words_done = words_done;
        flit_taken      = 1'b0;
        crc_error       = 1'b0;
        crc_clear       = 1'b0;
        crc_update      = 1'b0;
        buf_wen         = 1'b0;
        req_push        = 1'b0;

        case (state)
            IDLE: begin
                crc_clear = 1'b1;
                if (flit_valid) begin
                    next_state = HEADER;
                end
            end
            HEADER: begin
                next_words_done = '0;
                next_state      = CRC_WAIT;
            end
            CRC_WAIT: begin
                crc_update = !crc_done;
                if (crc_done) begin
                    flit_taken      = 1'b1;
                    buf_wen         = 1'b1;
                    next_waddr      = buf_waddr + BUF_AW'(1);
                    next_words_done = words_done + CNT_W'(1);
                    next_state      = BODY;
                end
            end
            BODY: begin
                if (flit_valid) begin
                    next_state = last_word ? CRC_CHECK : CRC_WAIT;
                end
            end
            CRC_CHECK: begin
                flit_taken = 1'b1; // the CRC word is consumed either way.
                if (crc_value == flit_payload) begin
                    next_state = REQ_EN;
                end else begin
                    crc_error  = 1'b1;
                    next_waddr = start_addr; // the next packet overwrites this one.
                    next_state = IDLE;
                end
            end
            REQ_EN: begin
                if (!req_full) begin
                    req_push   = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_comb begin
        credit_granted          = '0;
        credit_granted[flit_vc] = flit_taken;
    end

    // a flit stays offered until it is taken, so a take never finds the port empty.
    a_take_needs_valid: assert property (
        @(posedge clk) disable iff (!n_rst) flit_taken |-> flit_valid
    );

endmodule

// File: rtl/crc_unit.sv
module crc_unit (
    input  logic            clk,
    input  logic            n_rst,
    input  logic            clear,
    input  logic            update,
    input  flit_pkg::word_t data_in,
    output flit_pkg::word_t crc_value,
    output logic            done
);

    logic [1:0] byte_sel;
    logic [7:0] cur_byte;

    function automatic flit_pkg::word_t fold_byte(flit_pkg::word_t crc, logic [7:0] data);
        flit_pkg::word_t c;
        c = crc ^ {data, 24'h00_0000};
        for (int i = 0; i < 8; i++) begin
            if (c[31]) begin
                c = (c << 1) ^ flit_pkg::CRC_POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    assign cur_byte = data_in[8*(3-byte_sel) +: 8]; // most significant byte goes first.

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_value <= flit_pkg::CRC_SEED;
            byte_sel  <= 2'd0;
            done      <= 1'b0;
        end else if (clear) begin
            crc_value <= flit_pkg::CRC_SEED;
            byte_sel  <= 2'd0;
            done      <= 1'b0;
        end else if (update && !done) begin
            crc_value <= fold_byte(crc_value, cur_byte);
            byte_sel  <= byte_sel + 2'd1; // wraps to zero after the fourth byte.
            done      <= (byte_sel == 2'd3);
        end else if (!update) begin
            done <= 1'b0;
        end
    end

    // the receive FSM clears only between packets and updates only inside one.
    a_clear_update_excl: assert property (
        @(posedge clk) disable iff (!n_rst) !(clear && update)
    );

endmodule

// File: rtl/rx_pkg.sv
package rx_pkg;

    localparam int BUF_AW = 6; // receive buffer holds 64 words.

    typedef struct packed {
        flit_pkg::flit_id_t id;
        flit_pkg::req_e     req;
    } meta_t;

    typedef struct packed {
        meta_t             meta;
        logic [BUF_AW-1:0] addr; // buffer address of the packet header.
    } req_entry_t;

endpackage

// File: rtl/flit_pkg.sv
package flit_pkg;

    typedef logic [31:0] word_t;

    typedef logic [4:0] flit_id_t;

    typedef enum logic [1:0] {
        READ   = 2'd0,
        WRITE  = 2'd1,
        ATOMIC = 2'd2,
        MSG    = 2'd3
    } req_e;

    localparam int NUM_VC = 2; // credits are returned per virtual channel.

    // CRC-32, MSB first, no reflection and no final inversion.
    localparam word_t CRC_POLY = 32'h04C1_1DB7;
    localparam word_t CRC_SEED = 32'hFFFF_FFFF;

    localparam int MAX_DATA_WORDS = 15; // largest value of the header length field.

    function automatic logic [3:0] data_word_count(word_t header);
        return header[3:0]; // data words that follow this header.
    endfunction

endpackage
